/* source/imul_cfg_pkg.sv */
//--------------------------------------------------------------------------
// multiply unit configuration: lane count, operand width, iteration
// count and the lane control states
//--------------------------------------------------------------------------

package imul_cfg_pkg;

  // number of multiplier lanes working in parallel (1 to 8)
  localparam int IMUL_LANES = 4;

  // lane pointer width, at least one bit so a single lane still works
  localparam int IMUL_LANE_W = (IMUL_LANES > 1) ? $clog2(IMUL_LANES) : 1;

  // operand width in bits, two's complement
  localparam int IMUL_W = 32;

  // one add/shift step per multiplier bit
  localparam int IMUL_ITER = IMUL_W;

  // iteration counter width, 5 bits for 32 steps
  localparam int IMUL_CNT_W = $clog2(IMUL_ITER);

  // lane control states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } imul_state_e;

endpackage

/* source/imul_msg_pkg.sv */
//--------------------------------------------------------------------------
// multiply unit message formats for the request and response ports
//--------------------------------------------------------------------------

package imul_msg_pkg;

  //------------------------------------------------------------------------
  // request
  //------------------------------------------------------------------------

  // two signed operands, a in the upper half
  typedef struct packed {
    logic [imul_cfg_pkg::IMUL_W-1:0] a;
    logic [imul_cfg_pkg::IMUL_W-1:0] b;
  } imul_req_t;

  //------------------------------------------------------------------------
  // response
  //------------------------------------------------------------------------

  // full-width signed product, twice the operand width
  typedef logic [2*imul_cfg_pkg::IMUL_W-1:0] imul_prod_t;

endpackage

/* source/imul_dispatch.sv */
//--------------------------------------------------------------------------
// request dispatcher, hands accepted requests to the lanes in
// round-robin order
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_dispatch (
  input  logic                                clk,
  input  logic                                reset,

  input  imul_msg_pkg::imul_req_t             req_msg,
  input  logic                                req_val,
  output logic                                req_rdy,

  output imul_msg_pkg::imul_req_t             lane_req_msg,
  output logic [imul_cfg_pkg::IMUL_LANES-1:0] lane_req_val,
  input  logic [imul_cfg_pkg::IMUL_LANES-1:0] lane_req_rdy
);

  import imul_cfg_pkg::*;

  // lane that receives the next request
  logic [IMUL_LANE_W-1:0] send_ptr;

  // operands go to every lane, only the valid strobe is steered
  assign lane_req_msg = req_msg;

  // request side only sees the pointed lane
  assign req_rdy = lane_req_rdy[send_ptr];

  always_comb begin
    for (int i = 0; i < IMUL_LANES; i++) begin
      lane_req_val[i] = req_val && (send_ptr == IMUL_LANE_W'(i));
    end
  end

  // step to the next lane on every transfer, wrap at the last one
  always_ff @(posedge clk) begin
    if (reset) begin
      send_ptr <= '0;
    end else if (req_val && req_rdy) begin
      if (send_ptr == IMUL_LANE_W'(IMUL_LANES - 1)) begin
        send_ptr <= '0;
      end else begin
        send_ptr <= send_ptr + 1'b1;
      end
    end
  end

  //------------------------------------------------------------------------
  // checks
  //------------------------------------------------------------------------

  // never offer one request to two lanes
  a_one_lane_val: assert property (@(posedge clk) disable iff (reset)
    $onehot0(lane_req_val));

endmodule

/* source/imul_lane.sv */
//--------------------------------------------------------------------------
// iterative signed multiplier lane, 32 shift-and-add steps on the
// operand magnitudes then a sign fix on the 64-bit product
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_lane (
  input  logic                    clk,
  input  logic                    reset,

  input  imul_msg_pkg::imul_req_t req_msg,
  input  logic                    req_val,
  output logic                    req_rdy,

  output imul_msg_pkg::imul_prod_t resp_msg,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  import imul_cfg_pkg::*;
  import imul_msg_pkg::*;

  //------------------------------------------------------------------------
  // control
  //------------------------------------------------------------------------

  imul_state_e            state;
  logic [IMUL_CNT_W-1:0]  count;

  // start captures the operands, en/sel step the shift registers
  logic start;
  logic a_en;
  logic a_sel;
  logic b_en;
  logic b_sel;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // last step moves to done, counter wraps back to zero
          if (count == IMUL_CNT_W'(IMUL_ITER - 1)) begin
            state <= DONE;
          end
          count <= count + 1'b1;
        end
        DONE: begin
          if (resp_val && resp_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  assign start    = req_val && req_rdy;

  // first calc step loads from the magnitudes (sel 0), later ones shift
  assign a_en  = (state == CALC);
  assign b_en  = (state == CALC);
  assign a_sel = (count != '0);
  assign b_sel = (count != '0);

  //------------------------------------------------------------------------
  // datapath
  //------------------------------------------------------------------------

  logic              sign_a;
  logic              sign_b;
  logic [IMUL_W-1:0] mag_a;
  logic [IMUL_W-1:0] mag_b;
  imul_prod_t        mcand;
  logic [IMUL_W-1:0] mplier;
  imul_prod_t        acc;

  logic              in_sign_a;
  logic              in_sign_b;
  logic [IMUL_W-1:0] in_mag_a;
  logic [IMUL_W-1:0] in_mag_b;
  imul_prod_t        mcand_cur;
  logic [IMUL_W-1:0] mplier_cur;

  // magnitudes of the incoming operands
  assign in_sign_a = req_msg.a[IMUL_W-1];
  assign in_sign_b = req_msg.b[IMUL_W-1];
  assign in_mag_a  = in_sign_a ? (~req_msg.a + 1'b1) : req_msg.a;
  assign in_mag_b  = in_sign_b ? (~req_msg.b + 1'b1) : req_msg.b;

  // load-or-shift muxes
  assign mcand_cur  = a_sel ? mcand : {{IMUL_W{1'b0}}, mag_a};
  assign mplier_cur = b_sel ? mplier : mag_b;

  always_ff @(posedge clk) begin
    if (start) begin
      sign_a <= in_sign_a;
      sign_b <= in_sign_b;
      mag_a  <= in_mag_a;
      mag_b  <= in_mag_b;
      acc    <= '0;
    end else if (a_en) begin
      // add the multiplicand when the current multiplier bit is set
      acc <= mplier_cur[0] ? (acc + mcand_cur) : acc;
    end
    if (a_en) begin
      mcand <= mcand_cur << 1;
    end
    if (b_en) begin
      mplier <= mplier_cur >> 1;
    end
  end

  // product is negative when exactly one operand was
  assign resp_msg = (sign_a ^ sign_b) ? (~acc + 1'b1) : acc;

  //------------------------------------------------------------------------
  // checks
  //------------------------------------------------------------------------

  // held product does not move under back-pressure
  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_msg));

  // lane frees up only on the cycle after its product drained from done
  a_rdy_after_drain: assert property (@(posedge clk) disable iff (reset)
    $rose(req_rdy) |-> $past(state == DONE && resp_rdy));

  // result appears exactly 33 cycles after acceptance
  a_latency: assert property (@(posedge clk) disable iff (reset)
    req_val && req_rdy |-> ##1 (!resp_val) [*IMUL_ITER] ##1 resp_val);

endmodule

/* source/imul_collect.sv */
//--------------------------------------------------------------------------
// response collector, drains lane products in round-robin order so
// responses leave in request order
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_collect (
  input  logic                                clk,
  input  logic                                reset,

  input  imul_msg_pkg::imul_prod_t            lane_resp_msg [imul_cfg_pkg::IMUL_LANES],
  input  logic [imul_cfg_pkg::IMUL_LANES-1:0] lane_resp_val,
  output logic [imul_cfg_pkg::IMUL_LANES-1:0] lane_resp_rdy,

  output imul_msg_pkg::imul_prod_t            resp_msg,
  output logic                                resp_val,
  input  logic                                resp_rdy
);

  import imul_cfg_pkg::*;

  // lane whose product goes out next
  logic [IMUL_LANE_W-1:0] recv_ptr;

  // response port follows the pointed lane
  assign resp_msg = lane_resp_msg[recv_ptr];
  assign resp_val = lane_resp_val[recv_ptr];

  // ready goes back to the pointed lane alone
  always_comb begin
    for (int i = 0; i < IMUL_LANES; i++) begin
      lane_resp_rdy[i] = resp_rdy && (recv_ptr == IMUL_LANE_W'(i));
    end
  end

  // same stepping order as the dispatcher
  always_ff @(posedge clk) begin
    if (reset) begin
      recv_ptr <= '0;
    end else if (resp_val && resp_rdy) begin
      if (recv_ptr == IMUL_LANE_W'(IMUL_LANES - 1)) begin
        recv_ptr <= '0;
      end else begin
        recv_ptr <= recv_ptr + 1'b1;
      end
    end
  end

  //------------------------------------------------------------------------
  // checks
  //------------------------------------------------------------------------

  // a lane off the pointer never sees ready, so it can't drop its product
  a_rdy_pointed: assert property (@(posedge clk) disable iff (reset)
    (lane_resp_rdy & ~(IMUL_LANES'(1) << recv_ptr)) == '0);

endmodule

/* source/imul_unit.sv */
//--------------------------------------------------------------------------
// multiply unit top, dispatcher feeding parallel iterative lanes with
// an in-order collector on the response side
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_unit (
  input  logic                     clk,
  input  logic                     reset,

  input  imul_msg_pkg::imul_req_t  req_msg,
  input  logic                     req_val,
  output logic                     req_rdy,

  output imul_msg_pkg::imul_prod_t resp_msg,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  import imul_cfg_pkg::*;
  import imul_msg_pkg::*;

  // request fan-out
  imul_req_t              lane_req_msg;
  logic [IMUL_LANES-1:0]  lane_req_val;
  logic [IMUL_LANES-1:0]  lane_req_rdy;

  // response fan-in
  imul_prod_t             lane_resp_msg [IMUL_LANES];
  logic [IMUL_LANES-1:0]  lane_resp_val;
  logic [IMUL_LANES-1:0]  lane_resp_rdy;

  imul_dispatch u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_msg      (req_msg),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .lane_req_msg (lane_req_msg),
    .lane_req_val (lane_req_val),
    .lane_req_rdy (lane_req_rdy)
  );

  //------------------------------------------------------------------------
  // lane array
  //------------------------------------------------------------------------

  for (genvar i = 0; i < IMUL_LANES; i++) begin : g_lane
    imul_lane u_lane (
      .clk      (clk),
      .reset    (reset),
      .req_msg  (lane_req_msg),
      .req_val  (lane_req_val[i]),
      .req_rdy  (lane_req_rdy[i]),
      .resp_msg (lane_resp_msg[i]),
      .resp_val (lane_resp_val[i]),
      .resp_rdy (lane_resp_rdy[i])
    );
  end

  imul_collect u_collect (
    .clk           (clk),
    .reset         (reset),
    .lane_resp_msg (lane_resp_msg),
    .lane_resp_val (lane_resp_val),
    .lane_resp_rdy (lane_resp_rdy),
    .resp_msg      (resp_msg),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy)
  );

endmodule

/* test/imul_checker.sv */
//--------------------------------------------------------------------------
// response checker, predicts products from accepted requests and
// compares them in order against the response port
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_checker (
  input  logic                     clk,
  input  logic                     reset,
  input  imul_msg_pkg::imul_req_t  req_msg,
  input  logic                     req_val,
  input  logic                     req_rdy,
  input  imul_msg_pkg::imul_prod_t resp_msg,
  input  logic                     resp_val,
  input  logic                     resp_rdy,
  output int                       err_count,
  output int                       resp_count,
  output int                       pending
);

  import imul_cfg_pkg::*;
  import imul_msg_pkg::*;

  // expected products, oldest request first
  imul_prod_t expect_q[$];
  imul_prod_t exp_prod;

  // sign-extend both operands, low half of the wide product is exact
  function automatic imul_prod_t model_product(imul_req_t r);
    imul_prod_t wa;
    imul_prod_t wb;
    wa = {{IMUL_W{r.a[IMUL_W-1]}}, r.a};
    wb = {{IMUL_W{r.b[IMUL_W-1]}}, r.b};
    return wa * wb;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      expect_q.delete();
      err_count  <= 0;
      resp_count <= 0;
      pending    <= 0;
    end else begin
      if (req_val && req_rdy) begin
        expect_q.push_back(model_product(req_msg));
      end
      if (resp_val && resp_rdy) begin
        resp_count <= resp_count + 1;
        if (expect_q.size() == 0) begin
          $display("error at %0t: response %h with no request outstanding",
                   $time, resp_msg);
          err_count <= err_count + 1;
        end else begin
          exp_prod = expect_q.pop_front();
          if (resp_msg !== exp_prod) begin
            $display("error at %0t: product %h, expected %h", $time, resp_msg, exp_prod);
            err_count <= err_count + 1;
          end
        end
      end
      pending <= expect_q.size();
    end
  end

endmodule

/* test/imul_unit_tb.sv */
//--------------------------------------------------------------------------
// multiply unit testbench, LFSR operands and stalls, in-order checking
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module imul_unit_tb;

  import imul_cfg_pkg::*;
  import imul_msg_pkg::*;

  localparam int clk_period = 40;
  // random, corner pairings, stalled random, overlap burst
  localparam int total_ops  = 200 + 25 + 150 + IMUL_LANES;

  logic        clk;
  logic        reset;
  imul_req_t   req_msg;
  logic        req_val;
  logic        req_rdy;
  imul_prod_t  resp_msg;
  logic        resp_val;
  logic        resp_rdy;
  int          err_count;
  int          resp_count;
  int          pending;

  logic [15:0] lfsr;
  imul_req_t   ops_q[$];
  int          local_errs;
  int          errs_before;
  int          tests_passed;
  int          tests_failed;
  int          accepted;

  imul_unit dut (.*);
  imul_checker u_checker (.*);

  always #(clk_period / 2) clk = ~clk;

  //------------------------------------------------------------------------
  // random source
  //------------------------------------------------------------------------

  // galois LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 16'hb400;
    end
    return b;
  endfunction

  // three in four
  function automatic logic rand_go();
    logic b0;
    logic b1;
    b0 = rand_bit();
    b1 = rand_bit();
    return b0 | b1;
  endfunction

  function automatic imul_req_t rand_req();
    imul_req_t r;
    r = '0;
    for (int i = 0; i < 2 * IMUL_W; i++) begin
      r = {r[2*IMUL_W-2:0], rand_bit()};
    end
    return r;
  endfunction

  //------------------------------------------------------------------------
  // stimulus
  //------------------------------------------------------------------------

  task automatic fill_random(input int n);
    repeat (n) begin
      ops_q.push_back(rand_req());
    end
  endtask

  // zero, one, minus one, most negative, most positive in all pairings
  task automatic fill_corners();
    logic [IMUL_W-1:0] corner [5];
    imul_req_t         r;
    corner = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        r.a = corner[i];
        r.b = corner[j];
        ops_q.push_back(r);
      end
    end
  endtask

  // send the whole queue, run until every product is back
  task automatic run_stream(input logic stalls);
    int target;
    target = resp_count + ops_q.size();
    while (resp_count < target) begin
      @(posedge clk);
      // an offered request holds until it transfers
      if (!req_val || req_rdy) begin
        if (ops_q.size() > 0 && (!stalls || rand_go())) begin
          req_msg <= ops_q.pop_front();
          req_val <= 1'b1;
        end else begin
          req_val <= 1'b0;
        end
      end
      resp_rdy <= !stalls || rand_bit();
    end
    if (pending != 0) begin
      $display("%0d expected products never came back", pending);
      local_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_count + local_errs - errs_before;
    if (errs == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errs);
    end
    errs_before = err_count + local_errs;
  endtask

  //------------------------------------------------------------------------
  // test sequence
  //------------------------------------------------------------------------

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    req_msg     = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    lfsr        = 16'd27969;
    local_errs  = 0;
    errs_before = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
      $display("error at %0t: req_rdy %b resp_val %b after reset", $time, req_rdy, resp_val);
      local_errs++;
    end
    finish_test("reset state");
    fill_random(200);
    run_stream(1'b0);
    finish_test("random operands");
    fill_corners();
    run_stream(1'b0);
    finish_test("corner operands");
    fill_random(150);
    run_stream(1'b1);
    finish_test("random stalls");
    // hold responses off, only one request per lane can get in
    accepted = 0;
    resp_rdy <= 1'b0;
    req_val  <= 1'b1;
    req_msg  <= rand_req();
    repeat (2 * IMUL_ITER + IMUL_LANES) begin
      @(posedge clk);
      if (req_val && req_rdy) begin
        accepted++;
        req_msg <= rand_req();
      end
    end
    req_val <= 1'b0;
    if (accepted != IMUL_LANES) begin
      $display("error at %0t: %0d requests accepted with responses stalled, expected %0d",
               $time, accepted, IMUL_LANES);
      local_errs++;
    end
    resp_rdy <= 1'b1;
    while (pending != 0) begin
      @(posedge clk);
    end
    finish_test("lane overlap");
    $display("tests passed %0d, failed %0d, products checked %0d, errors %0d",
             tests_passed, tests_failed, resp_count, err_count + local_errs);
    if (tests_failed == 0 && err_count + local_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // watchdog, 80 cycles per operation
  initial begin
    #(total_ops * 80 * clk_period);
    $display("timeout: responses stopped arriving after %0d products", resp_count);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* flist.f */
source/imul_cfg_pkg.sv
source/imul_msg_pkg.sv
source/imul_dispatch.sv
source/imul_lane.sv
source/imul_collect.sv
source/imul_unit.sv
test/imul_checker.sv
test/imul_unit_tb.sv

/* Makefile */
# multiply unit simulation with Verilator
TOP = imul_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
